/* dv/cpu_asserts.sv */
`timescale 1ns/1ps
module cpuAsserts (
	input logic       clk,
	input logic       rstN,
	input logic       hlt,
	input logic       wbValid,
	input logic [3:0] wbReg
);

	// a reset edge empties writeback and clears the sticky halt
	resetClears: assert property (
		@(posedge clk) !rstN |=> !hlt && !wbValid
	) else $error("hlt or wbValid high in the cycle after reset");

	// halt is sticky
	hltSticky: assert property (
		@(posedge clk) $fell(hlt) |-> !$past(rstN)
	) else $error("hlt fell without a reset");

	noWriteAfterHlt: assert property (
		@(posedge clk) disable iff (!rstN) hlt |-> !wbValid
	) else $error("wbValid pulsed while hlt was high");

	// r0 writes are dropped in decode
	noR0Write: assert property (
		@(posedge clk) disable iff (!rstN) wbValid |-> wbReg != 4'd0
	) else $error("wbValid high with wbReg 0");

endmodule

bind cpu cpuAsserts u_asserts (
	.clk(clk),
	.rstN(rstN),
	.hlt(hlt),
	.wbValid(wbValid),
	.wbReg(wbReg)
);

/* dv/tbCpu.sv */
`timescale 1ns/1ps
module tbCpu;

	typedef struct packed {
		logic [3:0]  rd;
		logic [15:0] data;
	} traceT; // one retired register write

	localparam int progWords = 128;
	localparam int bodyWords = 112; // the rest stays hlt

	logic        clk;
	logic        rstN;
	logic        run;
	logic        progWe;
	logic [7:0]  progAddr;
	logic [15:0] progData;
	logic        hlt;
	logic [15:0] pc;
	logic        wbValid;
	logic [3:0]  wbReg;
	logic [15:0] wbData;

	logic [15:0] prog [progWords];
	logic [15:0] modelRegs [16];
	logic [15:0] modelMem [256];
	traceT       expQ [$]; // writes the model expects, oldest first
	int          errCount;
	int          writeCount;
	logic        checking;
	logic        hltSeen;
	logic        modelHalted;
	logic        timedOut;

	cpu #(
		.dmemWords(256),
		.imemWords(256)
	) u_cpu (
		.clk(clk),
		.rstN(rstN),
		.run(run),
		.progWe(progWe),
		.progAddr(progAddr),
		.progData(progData),
		.hlt(hlt),
		.pc(pc),
		.wbValid(wbValid),
		.wbReg(wbReg),
		.wbData(wbData)
	);

	initial clk = 1'b0;
	always #4 clk = ~clk; // 8 ns period

	function automatic logic [3:0] pickReg();
		return 4'($urandom_range(7, 0)); // small set, dense dependencies
	endfunction

	// random body, forward branches only, hlt fill so the run always ends
	task automatic genProgram();
		int          idx;
		logic [3:0]  rd;
		logic [15:0] tgt;
		for (int i = 0; i < progWords; i++)
			prog[i] = 16'hf000;
		idx = 0;
		while (idx < bodyWords) begin
			rd = 4'($urandom_range(7, 1));
			case ($urandom_range(12, 0))
				0, 1, 2, 3: prog[idx] = {4'($urandom_range(2, 0)), rd, pickReg(), pickReg()};
				4, 5: prog[idx] = {4'($urandom_range(6, 4)), rd, pickReg(), 4'($urandom())};
				6, 7: prog[idx] = {4'($urandom_range(11, 10)), rd, 8'($urandom())};
				8, 9: prog[idx] = {4'($urandom_range(9, 8)), rd, 4'h0, 4'($urandom())}; // base r0
				10: prog[idx] = {4'hc, 3'($urandom()), 9'($urandom_range(5, 0))};
				11: begin
					tgt = 16'((idx + 3 + int'($urandom_range(5, 0))) * 2); // byte address
					prog[idx] = {4'ha, rd, tgt[7:0]};
					prog[idx + 1] = {4'hb, rd, tgt[15:8]};
					prog[idx + 2] = {4'hd, 3'($urandom()), 1'b0, rd, 4'h0};
					idx = idx + 2;
				end
				default: prog[idx] = {4'he, rd, 8'h00}; // pcs
			endcase
			idx++;
		end
	endtask

	function automatic logic condTrue(input logic [2:0] ccc, input logic z, v, n);
		case (ccc)
			3'd0: return !z;
			3'd1: return z;
			3'd2: return !z && !n;
			3'd3: return n;
			3'd4: return z || !n;
			3'd5: return z || n;
			3'd6: return v;
			default: return 1'b1;
		endcase
	endfunction

	// {overflow, result}, clamped to the 16-bit signed range
	function automatic logic [16:0] satArith(input logic sub, input logic [15:0] a, b);
		int sa;
		int sb;
		int s;
		sa = int'($signed(a));
		sb = int'($signed(b));
		s = sub ? sa - sb : sa + sb;
		if (s > 32767)
			return {1'b1, 16'h7fff};
		if (s < -32768)
			return {1'b1, 16'h8000};
		return {1'b0, s[15:0]};
	endfunction

	task automatic logWrite(input logic [3:0] rd, input logic [15:0] val);
		traceT t;
		if (rd != 4'd0) begin
			modelRegs[rd] = val;
			t.rd = rd;
			t.data = val;
			expQ.push_back(t);
		end
	endtask

	// sequential ISA model of the loaded program
	task automatic runModel();
		logic [15:0] w;
		logic [15:0] res;
		logic [31:0] wide;
		logic [16:0] sr;
		logic [7:0]  addr;
		logic        z;
		logic        v;
		logic        n;
		int          idx;
		int          steps;
		for (int i = 0; i < 16; i++)
			modelRegs[i] = '0;
		for (int i = 0; i < 256; i++)
			modelMem[i] = '0;
		{z, v, n} = 3'b000;
		idx = 0;
		steps = 0;
		modelHalted = 1'b0;
		while (!modelHalted && steps < 1000 && idx < progWords) begin
			w = prog[idx];
			idx++; // now the next instruction
			steps++;
			addr = 8'(modelRegs[w[7:4]] + {{12{w[3]}}, w[3:0]});
			case (w[15:12])
				4'h0, 4'h1: begin
					sr = satArith(w[12], modelRegs[w[7:4]], modelRegs[w[3:0]]);
					{v, z, n} = {sr[16], sr[15:0] == 16'h0000, sr[15]};
					logWrite(w[11:8], sr[15:0]);
				end
				4'h2, 4'h4, 4'h5, 4'h6: begin
					wide = {{16{modelRegs[w[7:4]][15]}}, modelRegs[w[7:4]]} >> w[3:0];
					case (w[15:12])
						4'h2: res = modelRegs[w[7:4]] ^ modelRegs[w[3:0]];
						4'h4: res = modelRegs[w[7:4]] << w[3:0];
						4'h5: res = wide[15:0];
						default: res = (modelRegs[w[7:4]] >> w[3:0])
							| (modelRegs[w[7:4]] << (5'd16 - {1'b0, w[3:0]}));
					endcase
					z = (res == 16'h0000); // v and n untouched
					logWrite(w[11:8], res);
				end
				4'h8: logWrite(w[11:8], modelMem[addr]);
				4'h9: modelMem[addr] = modelRegs[w[11:8]];
				4'ha: logWrite(w[11:8], {modelRegs[w[11:8]][15:8], w[7:0]});
				4'hb: logWrite(w[11:8], {w[7:0], modelRegs[w[11:8]][7:0]});
				4'hc: if (condTrue(w[11:9], z, v, n)) idx = idx + int'($signed(w[8:0]));
				4'hd: if (condTrue(w[11:9], z, v, n)) idx = int'(modelRegs[w[7:4]][15:1]);
				4'he: logWrite(w[11:8], 16'(idx * 2));
				4'hf: modelHalted = 1'b1;
				default: ; // 3 and 7 do nothing
			endcase
		end
	endtask

	task automatic checkIdle();
		if (hlt !== 1'b0) begin
			$display("FAILED at %0t: hlt expected 0 got %b", $time, hlt);
			errCount++;
		end
		if (wbValid !== 1'b0) begin
			$display("FAILED at %0t: wbValid expected 0 got %b", $time, wbValid);
			errCount++;
		end
		if (pc !== 16'h0000) begin
			$display("FAILED at %0t: pc expected 0000 got %h", $time, pc);
			errCount++;
		end
	endtask

	// trace compare, sampled mid-cycle
	always @(negedge clk) begin
		traceT expW;
		if (checking) begin
			if (wbValid && hltSeen) begin
				$display("register write to r%0d after hlt at %0t", wbReg, $time);
				errCount++;
			end else if (wbValid && expQ.size() == 0) begin
				$display("register write to r%0d not in the model at %0t", wbReg, $time);
				errCount++;
			end else if (wbValid) begin
				expW = expQ.pop_front();
				writeCount++;
				if (wbReg !== expW.rd) begin
					$display("FAILED at %0t: wbReg expected %0d got %0d", $time, expW.rd, wbReg);
					errCount++;
				end
				if (wbData !== expW.data) begin
					$display("FAILED at %0t: wbData expected %h got %h", $time, expW.data, wbData);
					errCount++;
				end
			end
			if (hlt && !hltSeen) begin
				hltSeen = 1'b1;
				if (expQ.size() != 0) begin
					$display("hlt rose with %0d model writes still pending", expQ.size());
					errCount++;
				end
			end
		end
	end

	initial begin
		int          cycles;
		logic [15:0] stablePc;
		void'($urandom(32'h273f_8bea));
		{rstN, run, progWe, progAddr, progData} = '0;
		{errCount, writeCount} = '0;
		{checking, hltSeen, timedOut} = '0;
		genProgram();
		runModel();
		repeat (5) @(posedge clk);
		#1 rstN = 1'b1;
		@(negedge clk);
		checkIdle();
		for (int i = 0; i < progWords; i++) begin
			@(posedge clk);
			#1;
			progWe = 1'b1;
			progAddr = 8'(i);
			progData = prog[i];
		end
		@(posedge clk);
		#1 progWe = 1'b0;
		checking = 1'b1;
		run = 1'b1;
		cycles = 0;
		while (hlt !== 1'b1 && cycles < 3000) begin
			@(negedge clk);
			cycles++;
		end
		if (hlt !== 1'b1) begin
			$display("timeout: hlt never rose within %0d cycles", cycles);
			timedOut = 1'b1;
			errCount++;
		end else begin
			stablePc = pc;
			repeat (40) begin // quiet window after halt
				@(negedge clk);
				if (pc !== stablePc) begin
					$display("FAILED at %0t: pc expected %h got %h", $time, stablePc, pc);
					errCount++;
				end
				if (hlt !== 1'b1) begin
					$display("FAILED at %0t: hlt expected 1 got %b", $time, hlt);
					errCount++;
				end
			end
			if (!modelHalted || expQ.size() != 0) begin
				$display("model did not end at hlt or writes are missing (%0d left)", expQ.size());
				errCount++;
			end
			@(posedge clk);
			#1;
			checking = 1'b0;
			run = 1'b0;
			rstN = 1'b0;
			repeat (5) @(posedge clk);
			#1 rstN = 1'b1;
			repeat (4) begin
				@(negedge clk);
				checkIdle();
			end
		end
		$display("errors: %0d, register writes checked: %0d", errCount, writeCount);
		if (errCount == 0 && !timedOut) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

endmodule

/* run.sh */
#!/usr/bin/env bash
# build and run the cpu testbench with Verilator
cd "$(dirname "$0")" || exit 1

rm -rf obj_dir build.log sim.log

verilator --binary --assert -Wno-fatal --top-module tbCpu -f verilog.f \
	-Mdir obj_dir -o simCpu > build.log 2>&1 \
	|| { echo "build failed, see build.log"; exit 1; }

./obj_dir/simCpu > sim.log 2>&1 \
	|| echo "simulator exited with an error" >> sim.log

grep -q "test failed" sim.log && { echo "FAIL, see sim.log"; exit 1; }
grep -q "test passed" sim.log && { echo "PASS"; exit 0; }
echo "FAIL, no result in sim.log"
exit 1

/* src/aluCore.sv */
`timescale 1ns/1ps
module aluCore import cpuPkg::*; (
	input  logic [15:0] opA,
	input  logic [15:0] opB,
	input  opcodeE      op,
	input  logic [3:0]  shamt,
	output logic [15:0] result,
	output flagsT       flags
);

	logic [15:0] sum;
	logic [15:0] diff;
	logic        addOvf;
	logic        subOvf;
	logic [31:0] rotWide;

	// clamp toward the sign of opA
	function automatic logic [15:0] satVal(input logic neg);
		satVal = neg ? 16'h8000 : 16'h7fff;
	endfunction

	assign sum = opA + opB;
	assign diff = opA - opB;
	assign addOvf = (opA[15] == opB[15]) && (sum[15] != opA[15]); // like signs, sign flips
	assign subOvf = (opA[15] != opB[15]) && (diff[15] != opA[15]);
	assign rotWide = {opA, opA} >> shamt; // low half is the rotate

	always_comb begin
		result = '0;
		flags.v = 1'b0;
		case (op)
			ADD: begin
				result = addOvf ? satVal(opA[15]) : sum;
				flags.v = addOvf;
			end
			SUB: begin
				result = subOvf ? satVal(opA[15]) : diff;
				flags.v = subOvf;
			end
			XOR: begin
				result = opA ^ opB;
			end
			SLL: begin
				result = opA << shamt;
			end
			SRA: begin
				result = $signed(opA) >>> shamt; // keeps sign
			end
			ROR: begin
				result = rotWide[15:0];
			end
			default: begin
				result = '0; // non alu ops
			end
		endcase
		flags.z = (result == 16'h0000);
		flags.n = result[15];
	end

endmodule

/* src/controlUnit.sv */
`timescale 1ns/1ps
module controlUnit import cpuPkg::*; (
	input  instrU instr,
	output ctrlT  ctrl
);

	always_comb begin
		ctrl = '0; // unlisted opcodes fall out as nop
		ctrl.srcA = instr.rFmt.rs;
		ctrl.srcB = instr.rFmt.rt;
		ctrl.dst = instr.rFmt.rd;
		ctrl.aluOp = instr.rFmt.opcode;
		ctrl.ccc = instr.bFmt.ccc;
		case (instr.rFmt.opcode)
			ADD, SUB: begin
				ctrl.regWrite = 1'b1;
				ctrl.setZ = 1'b1;
				ctrl.setVN = 1'b1; // only arithmetic touches v and n
			end
			XOR: begin
				ctrl.regWrite = 1'b1;
				ctrl.setZ = 1'b1;
			end
			SLL, SRA, ROR: begin
				ctrl.regWrite = 1'b1;
				ctrl.setZ = 1'b1;
				ctrl.imm = {12'h000, instr.rFmt.rt}; // shift amount
			end
			LW, SW: begin
				ctrl.aluOp = ADD; // address adder
				ctrl.useImm = 1'b1;
				ctrl.imm = {{12{instr.rFmt.rt[3]}}, instr.rFmt.rt};
				ctrl.regWrite = (instr.rFmt.opcode == LW);
				ctrl.memRead = (instr.rFmt.opcode == LW);
				ctrl.memWrite = (instr.rFmt.opcode == SW);
				ctrl.srcB = instr.rFmt.rd; // store data comes from rd
			end
			LLB, LHB: begin
				ctrl.regWrite = 1'b1;
				ctrl.byteLoad = 1'b1;
				ctrl.loadHigh = (instr.iFmt.opcode == LHB);
				ctrl.srcB = instr.iFmt.rd; // old value to merge into
				ctrl.imm = {8'h00, instr.iFmt.imm8};
			end
			B: begin
				ctrl.branch = 1'b1;
				ctrl.imm = {{6{instr.bFmt.imm9[8]}}, instr.bFmt.imm9, 1'b0}; // byte offset
			end
			BR: begin
				ctrl.branchReg = 1'b1; // target read through srcA
			end
			PCS: begin
				ctrl.regWrite = 1'b1;
				ctrl.link = 1'b1;
			end
			HLT: begin
				ctrl.halt = 1'b1;
			end
			default: begin
				ctrl.aluOp = ADD; // nop
			end
		endcase
		if (ctrl.dst == 4'd0)
			ctrl.regWrite = 1'b0; // r0 is hardwired, drop the write
	end

endmodule

/* src/cpu.sv */
`timescale 1ns/1ps
module cpu import cpuPkg::*; #(
	parameter int dmemWords = 256,
	parameter int imemWords = 256
) (
	input  logic        clk,
	input  logic        rstN,
	input  logic        run,
	input  logic        progWe,
	input  logic [7:0]  progAddr,
	input  logic [15:0] progData,
	output logic        hlt,
	output logic [15:0] pc,
	output logic        wbValid,
	output logic [3:0]  wbReg,
	output logic [15:0] wbData
);

	localparam int imemAw = $clog2(imemWords);

	typedef struct packed {
		instrU       instr;
		logic [15:0] pcPlus2;
		logic        valid;
	} fetchT;

	logic [15:0] imem [imemWords];
	fetchT       fetchQ; // fetch -> execute
	exWbT        exWb; // execute -> writeback
	exWbT        exWbNext;
	ctrlT        exCtrl;
	flagsT       flagsQ;
	flagsT       aluFlags;
	logic [15:0] rfA;
	logic [15:0] rfB;
	logic [15:0] opA; // forwarded operands
	logic [15:0] fwdB;
	logic [15:0] aluOut;
	logic [15:0] loadResult;
	logic [15:0] branchTarget;
	logic        takeBranch;
	logic        exHalt;
	logic        haltSeen; // hlt has passed execute, fetch stays dead
	logic        hltQ;

	// ccc decode against stored flags
	function automatic logic condMet(input logic [2:0] ccc, input flagsT f);
		case (ccc)
			3'b000: condMet = !f.z; // neq
			3'b001: condMet = f.z; // eq
			3'b010: condMet = !f.z && !f.n; // gt
			3'b011: condMet = f.n; // lt
			3'b100: condMet = f.z || (!f.z && !f.n); // gte
			3'b101: condMet = f.n || f.z; // lte
			3'b110: condMet = f.v; // ovfl
			default: condMet = 1'b1; // unconditional
		endcase
	endfunction

	always_ff @(posedge clk) begin
		if (progWe)
			imem[progAddr[imemAw-1:0]] <= progData; // loader port, any time
	end

	controlUnit u_ctrl (
		.instr(fetchQ.instr),
		.ctrl(exCtrl)
	);

	regFile u_rf (
		.clk(clk),
		.rstN(rstN),
		.srcA(exCtrl.srcA),
		.srcB(exCtrl.srcB),
		.dst(wbReg),
		.writeEn(wbValid),
		.writeData(wbData),
		.dataA(rfA),
		.dataB(rfB)
	);

	assign opA = (wbValid && wbReg == exCtrl.srcA) ? wbData : rfA; // wb -> ex bypass
	assign fwdB = (wbValid && wbReg == exCtrl.srcB) ? wbData : rfB;

	aluCore u_alu (
		.opA(opA),
		.opB(exCtrl.useImm ? exCtrl.imm : fwdB),
		.op(exCtrl.aluOp),
		.shamt(exCtrl.imm[3:0]),
		.result(aluOut),
		.flags(aluFlags)
	);

	assign takeBranch = fetchQ.valid && (exCtrl.branch || exCtrl.branchReg)
		&& condMet(exCtrl.ccc, flagsQ);
	assign branchTarget = exCtrl.branchReg ? opA : fetchQ.pcPlus2 + exCtrl.imm;
	assign exHalt = fetchQ.valid && exCtrl.halt;

	always_comb begin
		exWbNext.ctrl = exCtrl;
		exWbNext.ctrl.regWrite = exCtrl.regWrite && fetchQ.valid; // bubbles write nothing
		exWbNext.ctrl.memWrite = exCtrl.memWrite && fetchQ.valid;
		exWbNext.ctrl.halt = exHalt;
		exWbNext.aluResult = aluOut;
		exWbNext.storeData = fwdB;
		exWbNext.linkPc = fetchQ.pcPlus2; // pcs value
		exWbNext.valid = fetchQ.valid;
	end

	// pc and fetch register
	always_ff @(posedge clk) begin
		fetchQ.instr <= imem[pc[imemAw:1]];
		fetchQ.pcPlus2 <= pc + 16'd2;
		if (!rstN) begin
			pc <= '0;
			fetchQ.valid <= 1'b0;
			haltSeen <= 1'b0;
		end else begin
			if (exHalt)
				haltSeen <= 1'b1;
			if (exHalt || haltSeen) begin
				fetchQ.valid <= 1'b0; // pc frozen
			end else if (!run) begin
				pc <= '0;
				fetchQ.valid <= 1'b0;
			end else if (takeBranch) begin
				pc <= branchTarget;
				fetchQ.valid <= 1'b0; // squash the wrong-path fetch
			end else begin
				pc <= pc + 16'd2;
				fetchQ.valid <= 1'b1;
			end
		end
	end

	// writeback register, flags and sticky halt
	always_ff @(posedge clk) begin
		if (!rstN) begin
			exWb <= '0;
			flagsQ <= '0;
			hltQ <= 1'b0;
		end else begin
			exWb <= exWbNext; // no stall path
			if (fetchQ.valid && exCtrl.setZ)
				flagsQ.z <= aluFlags.z;
			if (fetchQ.valid && exCtrl.setVN) begin
				flagsQ.v <= aluFlags.v;
				flagsQ.n <= aluFlags.n;
			end
			if (exWb.valid && exWb.ctrl.halt)
				hltQ <= 1'b1;
		end
	end

	memStage #(
		.dmemWords(dmemWords)
	) u_mem (
		.clk(clk),
		.rstN(rstN),
		.stage(exWb),
		.loadResult(loadResult)
	);

	assign hlt = hltQ || (exWb.valid && exWb.ctrl.halt); // rises as hlt enters wb
	assign wbValid = exWb.valid && exWb.ctrl.regWrite;
	assign wbReg = exWb.ctrl.dst;

	always_comb begin
		if (exWb.ctrl.link)
			wbData = exWb.linkPc;
		else if (exWb.ctrl.memRead || exWb.ctrl.byteLoad)
			wbData = loadResult; // lw or byte merge
		else
			wbData = exWb.aluResult;
	end

endmodule

/* src/cpuPkg.sv */
package cpuPkg;

	typedef enum logic [3:0] {
		ADD = 4'h0, // saturating add
		SUB = 4'h1, // saturating subtract
		XOR = 4'h2,
		SLL = 4'h4, // shifts take imm4 as amount
		SRA = 4'h5,
		ROR = 4'h6,
		LW  = 4'h8, // rd <- mem[rs + sext(imm4)]
		SW  = 4'h9, // mem[rs + sext(imm4)] <- rd
		LLB = 4'hA, // low byte of rd <- imm8
		LHB = 4'hB, // high byte of rd <- imm8
		B   = 4'hC, // pc relative, conditional
		BR  = 4'hD, // target in rs, conditional
		PCS = 4'hE, // rd <- pc + 2
		HLT = 4'hF
	} opcodeE; // 3 and 7 are unused, treated as nop

	typedef union packed {
		struct packed {
			opcodeE     opcode;
			logic [3:0] rd;
			logic [3:0] rs;
			logic [3:0] rt; // also imm4 for shifts and memory ops
		} rFmt;
		struct packed {
			opcodeE     opcode;
			logic [3:0] rd;
			logic [7:0] imm8; // llb/lhb byte
		} iFmt;
		struct packed {
			opcodeE     opcode;
			logic [2:0] ccc; // branch condition
			logic [8:0] imm9; // word offset for B
		} bFmt;
	} instrU;

	typedef struct packed {
		logic z;
		logic v;
		logic n;
	} flagsT;

	typedef struct packed {
		logic [3:0]  srcA; // first read port
		logic [3:0]  srcB; // second read port, also store / merge source
		logic [3:0]  dst;
		logic        regWrite;
		logic        memRead;
		logic        memWrite;
		logic        byteLoad; // llb or lhb
		logic        loadHigh; // lhb when byteLoad set
		logic        useImm; // alu opB from imm
		logic        branch;
		logic        branchReg;
		logic        link; // pcs
		logic        halt;
		logic        setZ;
		logic        setVN;
		opcodeE      aluOp;
		logic [15:0] imm;
		logic [2:0]  ccc;
	} ctrlT;

	typedef struct packed {
		ctrlT        ctrl;
		logic [15:0] aluResult; // also the data address
		logic [15:0] storeData; // sw data or old rd for byte merge
		logic [15:0] linkPc;
		logic        valid;
	} exWbT;

endpackage

/* src/memStage.sv */
`timescale 1ns/1ps
module memStage import cpuPkg::*; #(
	parameter int dmemWords = 256
) (
	input  logic        clk,
	input  logic        rstN,
	input  exWbT        stage,
	output logic [15:0] loadResult
);

	localparam int dmemAw = $clog2(dmemWords);

	logic [15:0]       dmem [dmemWords];
	logic [dmemAw-1:0] addr;
	logic [7:0]        imm8;
	logic [15:0]       oldRd;

	assign addr = stage.aluResult[dmemAw-1:0]; // word index, wraps modulo depth
	assign imm8 = stage.ctrl.imm[7:0];
	assign oldRd = stage.storeData; // rd value read in execute

	// store lands on the edge closing writeback
	always_ff @(posedge clk) begin
		if (!rstN) begin
			for (int i = 0; i < dmemWords; i++)
				dmem[i] <= '0;
		end else if (stage.ctrl.memWrite) begin
			dmem[addr] <= stage.storeData;
		end
	end

	always_comb begin
		if (stage.ctrl.byteLoad) begin
			if (stage.ctrl.loadHigh)
				loadResult = {imm8, oldRd[7:0]}; // lhb
			else
				loadResult = {oldRd[15:8], imm8}; // llb
		end else if (stage.ctrl.memRead) begin
			loadResult = dmem[addr]; // async read
		end else begin
			loadResult = '0;
		end
	end

endmodule

/* src/regFile.sv */
`timescale 1ns/1ps
module regFile (
	input  logic        clk,
	input  logic        rstN,
	input  logic [3:0]  srcA,
	input  logic [3:0]  srcB,
	input  logic [3:0]  dst,
	input  logic        writeEn,
	input  logic [15:0] writeData,
	output logic [15:0] dataA,
	output logic [15:0] dataB
);

	logic [15:0] regs [16];

	always_ff @(posedge clk) begin
		if (!rstN) begin
			for (int i = 0; i < 16; i++)
				regs[i] <= '0;
		end else if (writeEn && dst != 4'd0) begin
			regs[dst] <= writeData; // r0 never written
		end
	end

	// read ports see a write landing this cycle
	always_comb begin
		if (srcA == 4'd0)
			dataA = '0;
		else if (writeEn && dst == srcA)
			dataA = writeData; // bypass
		else
			dataA = regs[srcA];
	end

	always_comb begin
		if (srcB == 4'd0)
			dataB = '0;
		else if (writeEn && dst == srcB)
			dataB = writeData; // bypass
		else
			dataB = regs[srcB];
	end

endmodule

/* verilog.f */
src/cpuPkg.sv
src/controlUnit.sv
src/regFile.sv
src/aluCore.sv
src/memStage.sv
src/cpu.sv
dv/cpu_asserts.sv
dv/tbCpu.sv
